//--- memPkg.sv
// shared types for the dual-core memory system
// word and address types, core count
// request opcode, arbiter state and RAM status enums

package memPkg;

   // data word and byte address
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   // the system is built for exactly two cores
   localparam int cpuCount = 2;

   // request kind presented by a core port to the arbiter
   typedef enum logic [1:0] {
      OP_NONE,
      OP_IFETCH,
      OP_DREAD,
      OP_DWRITE
   } memOp_t;

   // arbiter FSM states
   typedef enum logic [1:0] {
      IDLE,
      SERVE0,
      SERVE1
   } arbState_t;

   // RAM status as seen by the arbiter
   typedef enum logic [1:0] {
      FREE,
      BUSY,
      ACCESS
   } ramState_t;

endpackage

//--- ramModel.sv
// behavioural word RAM with fixed latency
// BUSY for ramLatency cycles, then one ACCESS cycle
// writes commit on the ACCESS edge, reads shown during ACCESS

`timescale 1ns/1ps

module ramModel #(
   parameter int ramLatency = 2,
   parameter int memDepth   = 256
) (
   input  logic                CLK,
   input  logic                nRST,
   input  logic                ramREN,
   input  logic                ramWEN,
   input  memPkg::addr_t       ramAddr,
   input  memPkg::word_t       ramStore,
   output memPkg::ramState_t   ramState,
   output memPkg::word_t       ramLoad
);
   import memPkg::*;

   localparam int idxWidth = (memDepth > 1) ? $clog2(memDepth) : 1;
   localparam int cntWidth = $clog2(ramLatency + 1) + 1;

   word_t                mem [memDepth];
   logic [cntWidth-1:0]  latCount;
   logic [idxWidth-1:0]  wordIdx;
   logic                 active;

   // byte address to word index, wraps at memDepth
   assign wordIdx = ramAddr[idxWidth+1:2];
   assign active  = ramREN | ramWEN;

   always_comb begin
      if (!active) begin
         ramState = FREE;
      end else if (latCount == cntWidth'(ramLatency)) begin
         ramState = ACCESS;
      end else begin
         ramState = BUSY;
      end
   end

   // latency counter restarts after each ACCESS
   always_ff @(posedge CLK) begin
      if (!nRST) begin
         latCount <= '0;
      end else if (!active || ramState == ACCESS) begin
         latCount <= '0;
      end else begin
         latCount <= latCount + 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (!nRST) begin
         for (int i = 0; i < memDepth; i++) begin
            mem[i] <= '0;
         end
      end else if (ramWEN && ramState == ACCESS) begin
         mem[wordIdx] <= ramStore;
      end
   end

   assign ramLoad = (ramState == ACCESS) ? mem[wordIdx] : '0;

   a_noRdWr : assert property (
      @(posedge CLK) disable iff (!nRST)
      !(ramREN && ramWEN)
   );

endmodule

//--- coreRequestPort.sv
// per-core request port
// picks data over instruction access, steers address and store data,
// forms the core's wait and load outputs from grant and done

`timescale 1ns/1ps

module coreRequestPort (
   input  logic            CLK,
   input  logic            nRST,
   input  logic            iREN,
   input  logic            dREN,
   input  logic            dWEN,
   input  memPkg::addr_t   iaddr,
   input  memPkg::addr_t   daddr,
   input  memPkg::word_t   dstore,
   input  logic            grant,
   input  logic            done,
   input  memPkg::word_t   ramLoad,
   output memPkg::memOp_t  op,
   output memPkg::addr_t   reqAddr,
   output memPkg::word_t   reqData,
   output logic            iwait,
   output logic            dwait,
   output memPkg::word_t   iload,
   output memPkg::word_t   dload
);
   import memPkg::*;

   logic dataReq;
   logic finish;
   logic dFinish;
   logic iFinish;

   assign dataReq = dREN | dWEN;

   // data access beats instruction fetch
   always_comb begin
      if (dWEN) begin
         op = OP_DWRITE;
      end else if (dREN) begin
         op = OP_DREAD;
      end else if (iREN) begin
         op = OP_IFETCH;
      end else begin
         op = OP_NONE;
      end
   end

   assign reqAddr = dataReq ? daddr : iaddr;
   assign reqData = dstore;

   // this port's transaction completes this cycle
   assign finish  = grant & done;
   assign dFinish = finish & dataReq;
   assign iFinish = finish & iREN & ~dataReq;

   // only the selected request sees its wait drop
   assign dwait = dataReq & ~dFinish;
   assign iwait = iREN & ~iFinish;

   assign dload = dFinish ? ramLoad : '0;
   assign iload = iFinish ? ramLoad : '0;

   // a core never reads and writes data at once
   a_noDataRdWr : assert property (
      @(posedge CLK) disable iff (!nRST)
      !(dREN && dWEN)
   );

   // request address held while the arbiter serves it
   a_addrStable : assert property (
      @(posedge CLK) disable iff (!nRST)
      (grant && !done && op != OP_NONE) |=> (reqAddr == $past(reqAddr))
   );

endmodule

//--- memArbiter.sv
// round-robin arbiter between the two core ports
// grant FSM with lastGrant fairness, RAM control mux,
// done pulse on the RAM ACCESS cycle

`timescale 1ns/1ps

module memArbiter (
   input  logic                            CLK,
   input  logic                            nRST,
   input  memPkg::memOp_t                  op0,
   input  memPkg::memOp_t                  op1,
   input  memPkg::addr_t                   addr0,
   input  memPkg::addr_t                   addr1,
   input  memPkg::word_t                   data0,
   input  memPkg::word_t                   data1,
   input  memPkg::ramState_t               ramState,
   output logic [memPkg::cpuCount-1:0]     grant,
   output logic                            done,
   output logic                            ramREN,
   output logic                            ramWEN,
   output memPkg::addr_t                   ramAddr,
   output memPkg::word_t                   ramStore
);
   import memPkg::*;

   arbState_t state;
   arbState_t nextState;
   logic      lastGrant;
   logic      req0;
   logic      req1;
   memOp_t    selOp;

   assign req0 = (op0 != OP_NONE);
   assign req1 = (op1 != OP_NONE);

   always_ff @(posedge CLK) begin
      if (!nRST) begin
         state     <= IDLE;
         // core 0 goes first after reset
         lastGrant <= 1'b1;
      end else begin
         state <= nextState;
         if (state == IDLE && nextState == SERVE0) begin
            lastGrant <= 1'b0;
         end else if (state == IDLE && nextState == SERVE1) begin
            lastGrant <= 1'b1;
         end
      end
   end

   // opcode, address and data of the granted core
   always_comb begin
      case (state)
         SERVE0: begin
            selOp    = op0;
            ramAddr  = addr0;
            ramStore = data0;
         end
         SERVE1: begin
            selOp    = op1;
            ramAddr  = addr1;
            ramStore = data1;
         end
         default: begin
            selOp    = OP_NONE;
            ramAddr  = '0;
            ramStore = '0;
         end
      endcase
   end

   assign ramREN = (selOp == OP_IFETCH) || (selOp == OP_DREAD);
   assign ramWEN = (selOp == OP_DWRITE);

   // the only place the RAM status is looked at
   assign done  = (state != IDLE) && (ramState == ACCESS);
   assign grant = {state == SERVE1, state == SERVE0};

   always_comb begin
      nextState = state;
      case (state)
         IDLE: begin
            if (req0 && req1) begin
               nextState = lastGrant ? SERVE0 : SERVE1;
            end else if (req0) begin
               nextState = SERVE0;
            end else if (req1) begin
               nextState = SERVE1;
            end
         end
         SERVE0, SERVE1: begin
            // a dropped request frees the RAM as well
            if (done || selOp == OP_NONE) begin
               nextState = IDLE;
            end
         end
         default: nextState = IDLE;
      endcase
   end

   a_grantOnehot : assert property (
      @(posedge CLK) disable iff (!nRST)
      $onehot0(grant)
   );

   // the RAM never completes while no core is served
   a_noAccessIdle : assert property (
      @(posedge CLK) disable iff (!nRST)
      (state == IDLE) |-> (ramState != ACCESS)
   );

endmodule

//--- memSystem.sv
// top level of the dual-core memory side
// two core request ports, the round-robin arbiter and the RAM

`timescale 1ns/1ps

module memSystem #(
   parameter int ramLatency = 2,
   parameter int memDepth   = 256
) (
   input  logic                                      CLK,
   input  logic                                      nRST,
   input  logic [memPkg::cpuCount-1:0]               iREN,
   input  logic [memPkg::cpuCount-1:0]               dREN,
   input  logic [memPkg::cpuCount-1:0]               dWEN,
   input  memPkg::addr_t [memPkg::cpuCount-1:0]      iaddr,
   input  memPkg::addr_t [memPkg::cpuCount-1:0]      daddr,
   input  memPkg::word_t [memPkg::cpuCount-1:0]      dstore,
   output logic [memPkg::cpuCount-1:0]               iwait,
   output logic [memPkg::cpuCount-1:0]               dwait,
   output memPkg::word_t [memPkg::cpuCount-1:0]      iload,
   output memPkg::word_t [memPkg::cpuCount-1:0]      dload
);
   import memPkg::*;

   memOp_t [cpuCount-1:0]  op;
   addr_t  [cpuCount-1:0]  reqAddr;
   word_t  [cpuCount-1:0]  reqData;
   logic   [cpuCount-1:0]  grant;
   logic                   done;
   logic                   ramREN;
   logic                   ramWEN;
   addr_t                  ramAddr;
   word_t                  ramStore;
   ramState_t              ramState;
   word_t                  ramLoad;

   coreRequestPort u_port0 (
      .CLK(CLK), .nRST(nRST),
      .iREN(iREN[0]), .dREN(dREN[0]), .dWEN(dWEN[0]),
      .iaddr(iaddr[0]), .daddr(daddr[0]), .dstore(dstore[0]),
      .grant(grant[0]), .done(done), .ramLoad(ramLoad),
      .op(op[0]), .reqAddr(reqAddr[0]), .reqData(reqData[0]),
      .iwait(iwait[0]), .dwait(dwait[0]), .iload(iload[0]), .dload(dload[0])
   );

   coreRequestPort u_port1 (
      .CLK(CLK), .nRST(nRST),
      .iREN(iREN[1]), .dREN(dREN[1]), .dWEN(dWEN[1]),
      .iaddr(iaddr[1]), .daddr(daddr[1]), .dstore(dstore[1]),
      .grant(grant[1]), .done(done), .ramLoad(ramLoad),
      .op(op[1]), .reqAddr(reqAddr[1]), .reqData(reqData[1]),
      .iwait(iwait[1]), .dwait(dwait[1]), .iload(iload[1]), .dload(dload[1])
   );

   memArbiter u_arb (
      .CLK(CLK), .nRST(nRST),
      .op0(op[0]), .op1(op[1]),
      .addr0(reqAddr[0]), .addr1(reqAddr[1]),
      .data0(reqData[0]), .data1(reqData[1]),
      .ramState(ramState),
      .grant(grant), .done(done),
      .ramREN(ramREN), .ramWEN(ramWEN),
      .ramAddr(ramAddr), .ramStore(ramStore)
   );

   ramModel #(
      .ramLatency(ramLatency),
      .memDepth(memDepth)
   ) u_ram (
      .CLK(CLK), .nRST(nRST),
      .ramREN(ramREN), .ramWEN(ramWEN),
      .ramAddr(ramAddr), .ramStore(ramStore),
      .ramState(ramState), .ramLoad(ramLoad)
   );

endmodule

//--- memSystemTb.sv
// testbench for the dual-core memory system
// random two-core traffic checked against a memory model,
// round-robin order, data priority and isolated latency checks

`timescale 1ns/1ps

module memSystemTb;
   import memPkg::*;

   localparam int ramLatency = 2;
   localparam int memDepth   = 256;
   localparam int numTrans   = 40;
   // random traffic plus the directed requests at the end
   localparam int totalTrans = cpuCount * numTrans + 4;
   localparam int limitCycles = totalTrans * 2 * (ramLatency + 2) + 100;

   logic                   CLK;
   logic                   nRST;
   logic  [cpuCount-1:0]   iREN;
   logic  [cpuCount-1:0]   dREN;
   logic  [cpuCount-1:0]   dWEN;
   addr_t [cpuCount-1:0]   iaddr;
   addr_t [cpuCount-1:0]   daddr;
   word_t [cpuCount-1:0]   dstore;
   logic  [cpuCount-1:0]   iwait;
   logic  [cpuCount-1:0]   dwait;
   word_t [cpuCount-1:0]   iload;
   word_t [cpuCount-1:0]   dload;

   integer seed;
   word_t  model [memDepth];
   memOp_t kindArr [cpuCount][numTrans];
   addr_t  addrArr [cpuCount][numTrans];
   word_t  dataArr [cpuCount][numTrans];
   int     lastCore;
   int     cycles;
   word_t  wrValue;

   memSystem #(
      .ramLatency(ramLatency),
      .memDepth(memDepth)
   ) u_dut (
      .CLK(CLK), .nRST(nRST),
      .iREN(iREN), .dREN(dREN), .dWEN(dWEN),
      .iaddr(iaddr), .daddr(daddr), .dstore(dstore),
      .iwait(iwait), .dwait(dwait), .iload(iload), .dload(dload)
   );

   always #50 CLK = ~CLK;

   task abortRun();
      $display("Some tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   task checkWord(input string testName, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("Fail %s: expected %h, actual %h", testName, expected, actual);
         abortRun();
      end
   endtask

   task checkCore(input string testName, input int expected, input int actual);
      if (expected != actual) begin
         $display("Fail %s: expected core %0d, actual core %0d", testName, expected, actual);
         abortRun();
      end
   endtask

   task checkFlag(input string testName, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("Fail %s: expected %b, actual %b", testName, expected, actual);
         abortRun();
      end
   endtask

   task checkCycles(input string testName, input int expected, input int actual);
      if (expected != actual) begin
         $display("Fail %s: expected %0d cycles, actual %0d cycles", testName, expected,
                  actual);
         abortRun();
      end
   endtask

   task checkMaxCycles(input string testName, input int limit, input int actual);
      if (actual > limit) begin
         $display("Fail %s: expected at most %0d cycles, actual %0d cycles", testName, limit,
                  actual);
         abortRun();
      end
   endtask

   // bits 1:0 dropped, word index wraps at the RAM depth
   function automatic int wordIndex(input addr_t a);
      return (a >> 2) % memDepth;
   endfunction

   // rising edges until the selected wait is seen low
   task automatic countUntilDone(input int core, input logic dataSide, output int n);
      n = 0;
      do begin
         @(posedge CLK);
         n++;
      end while (dataSide ? dwait[core] : iwait[core]);
   endtask

   task automatic driveRequest(input int core, input memOp_t kind, input addr_t addr,
                               input word_t data);
      iREN[core]   = (kind == OP_IFETCH);
      dREN[core]   = (kind == OP_DREAD);
      dWEN[core]   = (kind == OP_DWRITE);
      iaddr[core]  = addr;
      daddr[core]  = addr;
      dstore[core] = data;
   endtask

   // one core issuing back-to-back random requests
   task automatic runCore(input int core);
      memOp_t kind;
      addr_t  addr;
      int     idx;
      int     n;
      for (int i = 0; i < numTrans; i++) begin
         kind = kindArr[core][i];
         addr = addrArr[core][i];
         @(negedge CLK);
         driveRequest(core, kind, addr, dataArr[core][i]);
         countUntilDone(core, kind != OP_IFETCH, n);
         // at most the other core's transaction ahead of this one
         checkMaxCycles("contendedLatency", 2 * (ramLatency + 2), n);
         checkCore("roundRobin", 1 - lastCore, core);
         lastCore = core;
         idx = wordIndex(addr);
         case (kind)
            OP_IFETCH: checkWord("instrFetch", model[idx], iload[core]);
            OP_DREAD:  checkWord("readAfterWrite", model[idx], dload[core]);
            default:   model[idx] = dataArr[core][i];
         endcase
      end
      @(negedge CLK);
      driveRequest(core, OP_NONE, '0, '0);
   endtask

   initial begin
      repeat (limitCycles) @(posedge CLK);
      $display("Error: a request never completed before the watchdog ran out");
      abortRun();
   end

   initial begin
      CLK      = 1'b0;
      nRST     = 1'b0;
      iREN     = '0;
      dREN     = '0;
      dWEN     = '0;
      iaddr    = '0;
      daddr    = '0;
      dstore   = '0;
      seed     = 32'he58c;
      lastCore = 1;
      for (int i = 0; i < memDepth; i++) begin
         model[i] = '0;
      end
      // small window of 8 words, with random low bits and wrap offset
      for (int c = 0; c < cpuCount; c++) begin
         for (int i = 0; i < numTrans; i++) begin
            kindArr[c][i] = memOp_t'(($unsigned($random(seed)) % 3) + 1);
            addrArr[c][i] = (($random(seed) & 7) << 2) | ($random(seed) & 3);
            addrArr[c][i] = addrArr[c][i] + (($random(seed) & 1) * memDepth * 4);
            dataArr[c][i] = $random(seed);
         end
      end

      repeat (4) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;

      @(posedge CLK);
      for (int c = 0; c < cpuCount; c++) begin
         checkFlag("resetIwait", 1'b0, iwait[c]);
         checkFlag("resetDwait", 1'b0, dwait[c]);
      end

      // both cores start together, core 0 must complete first
      fork
         runCore(0);
         runCore(1);
      join
      repeat (3) @(posedge CLK);

      // fetch and read raised together on core 0
      @(negedge CLK);
      iREN[0]  = 1'b1;
      dREN[0]  = 1'b1;
      iaddr[0] = 32'h10;
      daddr[0] = 32'h14;
      countUntilDone(0, 1'b1, cycles);
      checkCycles("isolatedLatency", ramLatency + 2, cycles);
      checkFlag("dataPriority", 1'b1, iwait[0]);
      checkWord("priorityRead", model[wordIndex(32'h14)], dload[0]);
      @(negedge CLK);
      dREN[0] = 1'b0;
      countUntilDone(0, 1'b0, cycles);
      checkCycles("fetchLatency", ramLatency + 2, cycles);
      checkWord("priorityFetch", model[wordIndex(32'h10)], iload[0]);
      @(negedge CLK);
      iREN[0] = 1'b0;
      repeat (2) @(posedge CLK);

      // write through a wrapped address on core 1, then read it back
      wrValue = $random(seed);
      @(negedge CLK);
      driveRequest(1, OP_DWRITE, 32'h40c, wrValue);
      countUntilDone(1, 1'b1, cycles);
      checkCycles("writeLatency", ramLatency + 2, cycles);
      model[wordIndex(32'h40c)] = wrValue;
      @(negedge CLK);
      driveRequest(1, OP_DREAD, 32'h0d, '0);
      countUntilDone(1, 1'b1, cycles);
      checkWord("wrapReadBack", model[wordIndex(32'h0d)], dload[1]);
      @(negedge CLK);
      driveRequest(1, OP_NONE, '0, '0);
      repeat (2) @(posedge CLK);

      $display("All tests passed");
      $finish;
   end

endmodule

//--- list.f
memPkg.sv
ramModel.sv
coreRequestPort.sv
memArbiter.sv
memSystem.sv
memSystemTb.sv
